//--- verilog/fetchPkg.sv
package fetchPkg;

	////////////////////////////////////////////////////////////
	// Datapath types
	////////////////////////////////////////////////////////////

	// Byte address into the instruction space
	typedef logic [31:0] addrT;
	// Raw instruction word
	typedef logic [31:0] instrT;
	// Cause code handed on to the exception unit
	typedef logic [4:0] excCodeT;
	// Word index inside one ROM bank
	typedef logic [3:0] rowT;

	////////////////////////////////////////////////////////////
	// Memory map
	////////////////////////////////////////////////////////////

	// First fetch after reset
	localparam addrT RESET_PC = 32'h0000_3000;
	// Handler entry when an exception is taken
	localparam addrT EXC_VECTOR = 32'h0000_3080;
	// Legal fetch window 0x3000 to 0x30FC
	localparam addrT IMEM_BASE = 32'h0000_3000;
	localparam int IMEM_WORDS = 64;
	localparam addrT IMEM_LAST = IMEM_BASE + addrT'((IMEM_WORDS - 1) * 4);
	localparam string IMEM_FILE = "imem.hex";

	// Word interleave, bank picked by PC bits 3:2
	localparam int NUM_BANKS = 4;
	localparam int BANK_BITS = $clog2(NUM_BANKS);
	localparam int BANK_WORDS = IMEM_WORDS / NUM_BANKS;

	////////////////////////////////////////////////////////////
	// Exception codes and filler
	////////////////////////////////////////////////////////////

	// AdEL, bad fetch address
	localparam excCodeT EXC_ADEL = 5'd4;
	// No exception pending
	localparam excCodeT EXC_NONE = 5'd31;
	// sll r0,r0,0
	localparam instrT NOP_INSTR = 32'h0000_0000;

endpackage

//--- verilog/pcUnit.sv
`timescale 1ns/1ps

module pcUnit import fetchPkg::*;
(
	input logic clk,
	input logic rstN,
	input logic branch,
	input addrT branchTarget,
	input logic jump,
	input addrT jumpTarget,
	input logic excTaken,
	input logic eret,
	input addrT epc,
	input logic advance,
	output logic [NUM_BANKS-1:0] bankEn,
	output rowT bankRow,
	output logic issueValid,
	output addrT issuePc,
	output logic issueErr,
	output logic flush
);

	// Current fetch address
	addrT pc;
	addrT pcPlus4;
	// Prioritized redirect destination
	addrT target;
	// Byte offset into the ROM window
	addrT offset;
	logic fault;
	logic [BANK_BITS-1:0] bankSel;

	////////////////////////////////////////////////////////////
	// Redirect selection
	////////////////////////////////////////////////////////////

	// Any request kills the fetches in flight
	assign flush = excTaken | eret | jump | branch;

	always_comb
	begin
		// Exception first, then eret, jump, branch
		if (excTaken)
			target = EXC_VECTOR;
		else if (eret)
			target = epc;
		else if (jump)
			target = jumpTarget;
		else
			target = branchTarget;
	end

	assign pcPlus4 = pc + 32'd4;

	// Redirect wins over stall
	always_ff @(posedge clk)
	begin
		if (!rstN)
			pc <= RESET_PC;
		else if (flush)
			pc <= target;
		else if (advance)
			pc <= pcPlus4;
	end

	////////////////////////////////////////////////////////////
	// Fault check and bank addressing
	////////////////////////////////////////////////////////////

	// Misaligned or outside the ROM window
	assign fault = (pc[1:0] != 2'b00) || (pc < IMEM_BASE) || (pc > IMEM_LAST);

	assign offset = pc - IMEM_BASE;
	// Word bits pick the bank, bits above pick the row
	assign bankSel = pc[2 +: BANK_BITS];
	assign bankRow = offset[2 + BANK_BITS +: $bits(rowT)];

	// Wrong-path fetch in a redirect cycle is dropped
	// Nothing issues while in reset
	assign issueValid = rstN & advance & ~flush;
	assign issuePc = pc;
	assign issueErr = fault;

	always_comb
	begin
		// Faulted fetches leave every bank idle
		for (int b = 0; b < NUM_BANKS; b++)
			bankEn[b] = issueValid && !fault && (bankSel == BANK_BITS'(b));
	end

endmodule

//--- verilog/instrBank.sv
`timescale 1ns/1ps

module instrBank import fetchPkg::*;
#(
	// Which word of each group of NUM_BANKS this bank holds
	parameter int bankIndex = 0
)
(
	input logic clk,
	input logic en,
	input rowT row,
	output instrT data
);

	// Bank contents
	instrT mem [BANK_WORDS];
	// Full program image, only used while loading
	instrT image [IMEM_WORDS];

	////////////////////////////////////////////////////////////
	// Load time fill
	////////////////////////////////////////////////////////////

	initial
	begin
		$readmemh(IMEM_FILE, image);
		// Every NUM_BANKS-th word starting at bankIndex
		for (int r = 0; r < BANK_WORDS; r++)
			mem[r] = image[r * NUM_BANKS + bankIndex];
	end

	// Registered read
	// Holds last word while disabled so a stalled item keeps its data
	always_ff @(posedge clk)
	begin
		if (en)
			data <= mem[row];
	end

endmodule

//--- verilog/fetchBuffer.sv
`timescale 1ns/1ps

module fetchBuffer import fetchPkg::*;
(
	input logic clk,
	input logic rstN,
	input logic issueValid,
	input addrT issuePc,
	input logic issueErr,
	input logic flush,
	input instrT [NUM_BANKS-1:0] bankData,
	input logic outReady,
	output logic advance,
	output logic outValid,
	output addrT outPc,
	output addrT outPcPlus4,
	output instrT outInstr,
	output logic outErr,
	output excCodeT outExcCode
);

	// Tag of the fetch sitting in the bank read stage
	logic tagValid;
	addrT tagPc;
	logic tagErr;
	logic [BANK_BITS-1:0] tagBank;
	// Word returned by the bank this tag addressed
	instrT bankWord;

	////////////////////////////////////////////////////////////
	// Pipeline move
	////////////////////////////////////////////////////////////

	// Output slot free or being taken this cycle
	assign advance = ~outValid | outReady;

	assign tagBank = tagPc[2 +: BANK_BITS];
	assign bankWord = bankData[tagBank];

	// Valid bits
	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			tagValid <= 1'b0;
			outValid <= 1'b0;
			outErr <= 1'b0;
		end
		else if (flush)
		begin
			// Both slots hold wrong-path fetches
			tagValid <= 1'b0;
			outValid <= 1'b0;
		end
		else if (advance)
		begin
			tagValid <= issueValid;
			outValid <= tagValid;
			outErr <= tagErr;
		end
	end

	////////////////////////////////////////////////////////////
	// Payload
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (advance)
		begin
			// Capture the fetch entering the bank stage
			tagPc <= issuePc;
			tagErr <= issueErr;
			// Move the bank stage into the decode register
			outPc <= tagPc;
			outPcPlus4 <= tagPc + 32'd4;
			// Bad address becomes a nop tagged AdEL
			if (tagErr)
			begin
				outInstr <= NOP_INSTR;
				outExcCode <= EXC_ADEL;
			end
			else
			begin
				outInstr <= bankWord;
				outExcCode <= EXC_NONE;
			end
		end
	end

endmodule

//--- verilog/fetchTop.sv
`timescale 1ns/1ps

module fetchTop import fetchPkg::*;
(
	input logic clk,
	input logic rstN,
	input logic branch,
	input addrT branchTarget,
	input logic jump,
	input addrT jumpTarget,
	input logic excTaken,
	input logic eret,
	input addrT epc,
	input logic outReady,
	output logic outValid,
	output addrT outPc,
	output addrT outPcPlus4,
	output instrT outInstr,
	output logic outErr,
	output excCodeT outExcCode
);

	// PC unit to banks
	logic [NUM_BANKS-1:0] bankEn;
	rowT bankRow;
	// PC unit to buffer
	logic issueValid;
	addrT issuePc;
	logic issueErr;
	logic flush;
	// Buffer back to PC unit
	logic advance;
	// One registered word per bank
	instrT [NUM_BANKS-1:0] bankData;

	////////////////////////////////////////////////////////////
	// Address stage
	////////////////////////////////////////////////////////////

	pcUnit uPc (
		.clk(clk),
		.rstN(rstN),
		.branch(branch),
		.branchTarget(branchTarget),
		.jump(jump),
		.jumpTarget(jumpTarget),
		.excTaken(excTaken),
		.eret(eret),
		.epc(epc),
		.advance(advance),
		.bankEn(bankEn),
		.bankRow(bankRow),
		.issueValid(issueValid),
		.issuePc(issuePc),
		.issueErr(issueErr),
		.flush(flush)
	);

	// Interleaved ROM, all banks share the row
	genvar b;
	generate
		for (b = 0; b < NUM_BANKS; b++)
		begin : gBank
			instrBank #(.bankIndex(b)) uBank (
				.clk(clk),
				.en(bankEn[b]),
				.row(bankRow),
				.data(bankData[b])
			);
		end
	endgenerate

	// Bank select and decode register
	fetchBuffer uBuf (
		.clk(clk),
		.rstN(rstN),
		.issueValid(issueValid),
		.issuePc(issuePc),
		.issueErr(issueErr),
		.flush(flush),
		.bankData(bankData),
		.outReady(outReady),
		.advance(advance),
		.outValid(outValid),
		.outPc(outPc),
		.outPcPlus4(outPcPlus4),
		.outInstr(outInstr),
		.outErr(outErr),
		.outExcCode(outExcCode)
	);

endmodule

//--- verif/fetchAsserts.sv
`timescale 1ns/1ps

module fetchAsserts import fetchPkg::*;
(
	input logic clk,
	input logic rstN,
	input logic flush,
	input logic [NUM_BANKS-1:0] bankEn,
	input logic outReady,
	input logic outValid,
	input addrT outPc,
	input addrT outPcPlus4,
	input instrT outInstr,
	input logic outErr,
	input excCodeT outExcCode
);

	////////////////////////////////////////////////////////////
	// Decode side handshake
	////////////////////////////////////////////////////////////

	// Held item frozen until taken or flushed
	holdStable: assert property (@(posedge clk) disable iff (!rstN)
		(outValid && !outReady && !flush) |=> (outValid && $stable(outPc)
			&& $stable(outPcPlus4) && $stable(outInstr) && $stable(outErr)
			&& $stable(outExcCode)))
		else $error("Decode output changed while held by back-pressure");

	// Redirect empties the output slot
	flushEmpties: assert property (@(posedge clk) disable iff (!rstN)
		flush |=> !outValid)
		else $error("outValid high in the cycle after a flush");

	////////////////////////////////////////////////////////////
	// Bank enables
	////////////////////////////////////////////////////////////

	// At most one bank read per cycle
	oneBank: assert property (@(posedge clk) disable iff (!rstN)
		$onehot0(bankEn))
		else $error("More than one bank enabled at once");

endmodule

bind fetchTop fetchAsserts uAsserts (
	.clk(clk),
	.rstN(rstN),
	.flush(flush),
	.bankEn(bankEn),
	.outReady(outReady),
	.outValid(outValid),
	.outPc(outPc),
	.outPcPlus4(outPcPlus4),
	.outInstr(outInstr),
	.outErr(outErr),
	.outExcCode(outExcCode)
);

//--- verif/fetchTb.sv
`timescale 1ns/1ps

module fetchTb import fetchPkg::*;
();

	// Stimulus lengths in cycles
	localparam int PHASE_SEQ = 80;
	localparam int PHASE_STALL = 120;
	localparam int PHASE_MIX = 400;
	localparam int STALL_REDIRS = 4;
	localparam int DRAIN = 10;
	// Reset, phases, stalled redirects at 4 cycles each, final wait
	localparam int NUM_CYCLES = 2 + PHASE_SEQ + (STALL_REDIRS + 1) * 4 + PHASE_STALL
		+ PHASE_MIX + DRAIN + 2;
	localparam int WATCHDOG_NS = NUM_CYCLES * 40 + 2000;
	localparam int MIN_ITEMS = 100;
	// First byte past the ROM window
	localparam addrT IMEM_END = IMEM_BASE + addrT'(IMEM_WORDS * 4);

	logic clk;
	logic rstN;
	logic branch;
	addrT branchTarget;
	logic jump;
	addrT jumpTarget;
	logic excTaken;
	logic eret;
	addrT epc;
	logic outReady;
	logic outValid;
	addrT outPc;
	addrT outPcPlus4;
	instrT outInstr;
	logic outErr;
	excCodeT outExcCode;

	integer seed;
	int errors;
	int accepted;
	// PC that the next accepted item must carry
	addrT expPc;
	// Reference copy of the program
	instrT image [IMEM_WORDS];

	fetchTop UUT (
		.clk(clk),
		.rstN(rstN),
		.branch(branch),
		.branchTarget(branchTarget),
		.jump(jump),
		.jumpTarget(jumpTarget),
		.excTaken(excTaken),
		.eret(eret),
		.epc(epc),
		.outReady(outReady),
		.outValid(outValid),
		.outPc(outPc),
		.outPcPlus4(outPcPlus4),
		.outInstr(outInstr),
		.outErr(outErr),
		.outExcCode(outExcCode)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// Checking and reference model
	////////////////////////////////////////////////////////////

	task automatic checkValue(string what, logic [31:0] got, logic [31:0] expected);
		if (got !== expected)
		begin
			errors++;
			$display("Error at %0t ns: %s is %h, expected %h (item at %h)",
				$time, what, got, expected, expPc);
		end
	endtask

	task automatic checkItem();
		logic legal;
		int idx;
		legal = (expPc[1:0] == 2'b00) && (expPc >= IMEM_BASE) && (expPc < IMEM_END);
		checkValue("outPc", outPc, expPc);
		checkValue("outPcPlus4", outPcPlus4, expPc + 32'd4);
		if (legal)
		begin
			idx = int'((expPc - IMEM_BASE) >> 2);
			checkValue("outInstr", outInstr, image[idx]);
			checkValue("outErr", 32'(outErr), 32'd0);
			checkValue("outExcCode", 32'(outExcCode), 32'(EXC_NONE));
		end
		else
		begin
			// Bad fetch address turns into a nop with AdEL
			checkValue("outInstr", outInstr, NOP_INSTR);
			checkValue("outErr", 32'(outErr), 32'd1);
			checkValue("outExcCode", 32'(outExcCode), 32'(EXC_ADEL));
		end
	endtask

	// Inputs settle 1 ns after the edge, so the falling edge sees the next edge's values
	always @(negedge clk)
	begin
		if (rstN)
		begin
			// Handshake first since the item was fetched before any redirect
			if (outValid && outReady)
			begin
				checkItem();
				accepted++;
				expPc = expPc + 32'd4;
			end
			// Same priority as the fetch unit
			if (excTaken)
				expPc = EXC_VECTOR;
			else if (eret)
				expPc = epc;
			else if (jump)
				expPc = jumpTarget;
			else if (branch)
				expPc = branchTarget;
		end
	end

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	function automatic addrT randAligned();
		return IMEM_BASE + (addrT'($random(seed)) & 32'h0000_00FC);
	endfunction

	// Mostly legal targets, some misaligned, some outside the ROM
	function automatic addrT randTarget();
		int kind;
		logic [1:0] offs;
		addrT word;
		word = randAligned();
		kind = $unsigned($random(seed)) % 8;
		offs = 2'($random(seed));
		if (kind == 0)
			return word + addrT'((offs == 2'b00) ? 2'b10 : offs);
		else if (kind == 1)
			return offs[0] ? word - 32'h0000_1000 : word + 32'h0000_0100;
		else
			return word;
	endfunction

	task automatic clearRedirects();
		branch = 1'b0;
		jump = 1'b0;
		eret = 1'b0;
		excTaken = 1'b0;
	endtask

	task automatic driveCycle(int readyPct, int redirPct);
		int roll;
		logic [3:0] mask;
		@(posedge clk);
		#1;
		roll = $unsigned($random(seed)) % 100;
		outReady = roll < readyPct;
		// Targets change every cycle whether used or not
		branchTarget = randTarget();
		jumpTarget = randTarget();
		epc = randTarget();
		clearRedirects();
		roll = $unsigned($random(seed)) % 100;
		if (roll < redirPct)
		begin
			mask = 4'($random(seed));
			if (mask == 4'b0000)
				mask = 4'b0001;
			branch = mask[0];
			jump = mask[1];
			eret = mask[2];
			// Exceptions rarer than the rest
			excTaken = mask[3] && (($unsigned($random(seed)) % 2) == 0);
		end
	endtask

	task automatic runCycles(int count, int readyPct, int redirPct);
		repeat (count)
			driveCycle(readyPct, redirPct);
	endtask

	// Hold decode, then jump while the item is stuck in the output register
	task automatic redirectInStall(addrT target);
		runCycles(3, 0, 0);
		@(posedge clk);
		#1;
		outReady = 1'b0;
		jump = 1'b1;
		jumpTarget = target;
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence and watchdog
	////////////////////////////////////////////////////////////

	initial
	begin
		seed = 85652;
		errors = 0;
		accepted = 0;
		expPc = RESET_PC;
		$readmemh(IMEM_FILE, image);
		rstN = 1'b0;
		outReady = 1'b0;
		branchTarget = IMEM_BASE;
		jumpTarget = IMEM_BASE;
		epc = IMEM_BASE;
		clearRedirects();
		repeat (2) @(posedge clk);
		#1;
		rstN = 1'b1;
		// Straight run that walks off the end of the ROM into faults
		runCycles(PHASE_SEQ, 100, 0);
		redirectInStall(RESET_PC);
		// Back-pressure only
		runCycles(PHASE_STALL, 60, 0);
		repeat (STALL_REDIRS)
			redirectInStall(randAligned());
		// Everything mixed
		runCycles(PHASE_MIX, 70, 15);
		runCycles(DRAIN, 100, 0);
		repeat (2) @(posedge clk);
		if (accepted < MIN_ITEMS)
		begin
			errors++;
			$display("Too few items reached decode: only %0d accepted", accepted);
		end
		$display("Run finished with %0d errors over %0d accepted items", errors, accepted);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("Timeout: the test sequence did not finish within %0d ns", WATCHDOG_NS);
		$display("Something failed");
		$finish;
	end

endmodule

//--- imem.hex
// One 32-bit instruction word per line, first line at byte address 0x3000
3c081234
35085678
24090010
240a0001
01095821
012a6023
ad0b0000
8d0d0004
11a00003
000a5080
01495825
3c0c0000
358c3040
8d8e0000
25ce0001
ad8e0004
08000c14
240f0020
01ee7822
15e0fffe
0c000c20
03e00008
3c10abcd
3610ef01
00108100
00108902
02119024
0211982a
2a740010
12800002
24140005
00144040
42000018
401a6800
401b7000
277b0004
409b7000
03600008
24020001
24030002
00432020
00832822
00a43024
00a43825
00a44026
00a44827
30a600ff
34a70f00
38a8aaaa
2ca90100
8c0a3000
ac0a3004
a00b3008
800c300c
940d3010
a40e3014
1000fff8
24100040
1610fffe
0000000c
0000000d
3c1d0000
27bd2ffc
1000ffff

//--- filelist.f
verilog/fetchPkg.sv
verilog/pcUnit.sv
verilog/instrBank.sv
verilog/fetchBuffer.sv
verilog/fetchTop.sv
verif/fetchAsserts.sv
verif/fetchTb.sv

//--- run.sh
#!/bin/sh
# Build the fetch unit testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1
rm -f sim.log
# A failed build or an aborted run is logged as a failure too
verilator --binary --timing --assert -Wno-fatal -f filelist.f \
	--top-module fetchTb -o fetchSim \
	&& ./obj_dir/fetchSim > sim.log 2>&1 \
	|| echo "Something failed" >> sim.log
cat sim.log
grep -q "Something failed" sim.log && exit 1
exit 0
